// ==== Makefile ====
TOOL     := verilator
FLAGS    := --binary --timing -j 0
TOP      := tb_tl_sram_adapter
FILELIST := tl_sram_adapter.f

OBJ_DIR  := obj_dir
SIM      := $(OBJ_DIR)/V$(TOP)
SOURCES  := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# output stays visible, status comes from the search for the pass line
run: $(SIM)
	$(SIM) | awk '{ print } /^PASS: all tests$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJ_DIR)

// ==== source/atomic_alu.sv ====
// combinational ALU for TileLink arithmetic and logical atomics on one data word
`default_nettype none

module atomic_alu (
  input  wire tl_sram_pkg::atomic_fn_e fn_i,
  input  wire tl_sram_pkg::tl_data_t   a_i,
  input  wire tl_sram_pkg::tl_data_t   b_i,
  output tl_sram_pkg::tl_data_t        result_o
);

  import tl_sram_pkg::*;

  logic     lt_signed;
  logic     lt_unsigned;
  tl_data_t sum;

  // a is the word in memory, b the operand from the A channel
  assign lt_signed   = $signed(a_i) < $signed(b_i);
  assign lt_unsigned = a_i < b_i;
  // wraps around, no carry out
  assign sum         = a_i + b_i;

  always_comb begin
    case (fn_i)
      // arithmetic
      FnMin: begin
        result_o = lt_signed ? a_i : b_i;
      end
      FnMax: begin
        result_o = lt_signed ? b_i : a_i;
      end
      FnMinU: begin
        result_o = lt_unsigned ? a_i : b_i;
      end
      FnMaxU: begin
        result_o = lt_unsigned ? b_i : a_i;
      end
      FnAdd: begin
        result_o = sum;
      end
      // logical
      FnXor: result_o = a_i ^ b_i;
      FnOr: result_o = a_i | b_i;
      FnAnd: result_o = a_i & b_i;
      // swap stores the new operand, old word goes back in the response
      FnSwap: result_o = b_i;
      default: result_o = b_i;
    endcase
  end

endmodule

`default_nettype wire

// ==== source/sram_access_ctrl.sv ====
// execute stage: drives the SRAM port for one request, including read-modify-write atomics
`default_nettype none

module sram_access_ctrl (
  input  wire logic                   clk_i,
  input  wire logic                   rst_ni,
  input  wire logic                   req_start_i,
  input  wire tl_sram_pkg::sram_req_t req_i,
  input  wire logic                   sram_gnt_i,
  input  wire tl_sram_pkg::tl_data_t  sram_rdata_i,
  input  wire logic                   sram_rvalid_i,
  input  wire logic                   rsp_done_i,
  output logic                        idle_o,
  output logic                        sram_req_o,
  output logic                        sram_we_o,
  output tl_sram_pkg::sram_addr_t     sram_addr_o,
  output tl_sram_pkg::tl_data_t       sram_wdata_o,
  output tl_sram_pkg::tl_data_t       sram_wmask_o,
  output logic                        rsp_valid_o,
  output tl_sram_pkg::tl_data_t       rsp_rdata_o
);

  import tl_sram_pkg::*;

  typedef enum logic [2:0] {
    IDLE,
    ISSUE,
    WAIT_RDATA,
    WRITE_BACK,
    RESPOND
  } state_e;

  state_e   state_q;
  state_e   state_d;
  tl_data_t old_q;
  tl_data_t alu_result;
  logic     is_write;

  assign is_write = (req_i.op == OpWrite);
  assign idle_o   = (state_q == IDLE);

  // sram command, request held with stable fields until grant
  assign sram_req_o   = (state_q == ISSUE) | (state_q == WRITE_BACK);
  assign sram_we_o    = (state_q == WRITE_BACK) | ((state_q == ISSUE) & is_write);
  assign sram_addr_o  = req_i.addr;
  assign sram_wmask_o = mask_to_bits(req_i.mask);
  // atomics write the ALU result, plain puts the A data
  assign sram_wdata_o = (state_q == WRITE_BACK) ? alu_result : req_i.data;

  // a read ends on rvalid itself, so the word comes straight from the port
  assign rsp_rdata_o = (state_q == WAIT_RDATA) ? sram_rdata_i : old_q;

  always_comb begin
    state_d     = state_q;
    rsp_valid_o = 1'b0;
    case (state_q)
      IDLE: begin
        if (req_start_i) begin
          if (req_i.op == OpError) begin
            // no sram access, answer right away
            state_d     = RESPOND;
            rsp_valid_o = 1'b1;
          end else begin
            state_d = ISSUE;
          end
        end
      end
      ISSUE: begin
        if (sram_gnt_i) begin
          if (is_write) begin
            state_d     = RESPOND;
            rsp_valid_o = 1'b1;
          end else begin
            state_d = WAIT_RDATA;
          end
        end
      end
      WAIT_RDATA: begin
        if (sram_rvalid_i) begin
          if (req_i.op == OpAtomic) begin
            state_d = WRITE_BACK;
          end else begin
            state_d     = RESPOND;
            rsp_valid_o = 1'b1;
          end
        end
      end
      WRITE_BACK: begin
        if (sram_gnt_i) begin
          state_d     = RESPOND;
          rsp_valid_o = 1'b1;
        end
      end
      RESPOND: begin
        // wait until the host takes the D beat
        if (rsp_done_i) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // old word, operand of the atomic and returned in the response
  always_ff @(posedge clk_i) begin
    if ((state_q == WAIT_RDATA) && sram_rvalid_i) begin
      old_q <= sram_rdata_i;
    end
  end

  atomic_alu i_alu (
    .fn_i     (req_i.fn),
    .a_i      (old_q),
    .b_i      (req_i.data),
    .result_o (alu_result)
  );

endmodule

`default_nettype wire

// ==== source/tl_a_decode.sv ====
// A channel front end: accepts one beat when the adapter is idle and registers it decoded
`default_nettype none

module tl_a_decode (
  input  wire logic                   clk_i,
  input  wire logic                   rst_ni,
  input  wire logic                   tl_a_valid_i,
  input  wire tl_sram_pkg::tl_a_t     tl_a_i,
  input  wire logic                   idle_i,
  output logic                        tl_a_ready_o,
  output logic                        req_start_o,
  output tl_sram_pkg::sram_req_t      req_o
);

  import tl_sram_pkg::*;

  logic       a_ack;
  req_op_e    dec_op;
  atomic_fn_e dec_fn;

  // ready drops as soon as a beat is taken, before execute leaves idle
  assign tl_a_ready_o = idle_i & ~req_start_o;
  assign a_ack        = tl_a_valid_i & tl_a_ready_o;

  // opcode and param to request class and ALU function
  always_comb begin
    dec_op = OpError;
    dec_fn = FnSwap;
    case (tl_a_i.opcode)
      PutFullData, PutPartialData: dec_op = OpWrite;
      Get: dec_op = OpRead;
      ArithmeticData: begin
        // MIN, MAX, MINU, MAXU, ADD
        if (tl_a_i.param <= 3'd4) begin
          dec_op = OpAtomic;
          dec_fn = atomic_fn_e'({1'b0, tl_a_i.param});
        end
      end
      LogicalData: begin
        // XOR, OR, AND, SWAP follow the arithmetic codes
        if (tl_a_i.param <= 3'd3) begin
          dec_op = OpAtomic;
          dec_fn = atomic_fn_e'(FnXor + {2'b00, tl_a_i.param[1:0]});
        end
      end
      default: dec_op = OpError;
    endcase
  end

  // start pulse in the cycle after accept
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_start_o <= 1'b0;
    end else begin
      req_start_o <= a_ack;
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_ack) begin
      req_o <= '{
        op:     dec_op,
        fn:     dec_fn,
        addr:   tl_a_i.address[$clog2(TL_DBW) +: SRAM_AW],
        mask:   tl_a_i.mask,
        data:   tl_a_i.data,
        size:   tl_a_i.size,
        source: tl_a_i.source
      };
    end
  end

endmodule

`default_nettype wire

// ==== source/tl_d_response.sv ====
// D channel stage: forms the response and holds it stable until the host takes it
`default_nettype none

module tl_d_response (
  input  wire logic                   clk_i,
  input  wire logic                   rst_ni,
  input  wire tl_sram_pkg::sram_req_t req_i,
  input  wire logic                   rsp_valid_i,
  input  wire tl_sram_pkg::tl_data_t  rsp_rdata_i,
  input  wire logic                   tl_d_ready_i,
  output logic                        tl_d_valid_o,
  output tl_sram_pkg::tl_d_t          tl_d_o,
  output logic                        rsp_done_o
);

  import tl_sram_pkg::*;

  logic     has_data;
  logic     rsp_load;
  tl_data_t rdata_masked;

  // reads and atomics return data, puts and errors only an ack
  assign has_data     = (req_i.op == OpRead) | (req_i.op == OpAtomic);
  // bytes outside the request mask read as zero
  assign rdata_masked = rsp_rdata_i & mask_to_bits(req_i.mask);

  // the register takes a new response only while empty
  assign rsp_load   = rsp_valid_i & ~tl_d_valid_o;
  assign rsp_done_o = tl_d_valid_o & tl_d_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tl_d_valid_o <= 1'b0;
    end else if (rsp_load) begin
      tl_d_valid_o <= 1'b1;
    end else if (rsp_done_o) begin
      tl_d_valid_o <= 1'b0;
    end
  end

  // read data is only present for one cycle on the sram side,
  // so it is caught here and kept through any D stall
  always_ff @(posedge clk_i) begin
    if (rsp_load) begin
      tl_d_o <= '{
        opcode: has_data ? AccessAckData : AccessAck,
        size:   req_i.size,
        source: req_i.source,
        data:   has_data ? rdata_masked : '0,
        error:  (req_i.op == OpError)
      };
    end
  end

endmodule

`default_nettype wire

// ==== source/tl_sram_adapter.sv ====
// TL-UL to SRAM adapter top; one request in flight, decode then execute then response
`default_nettype none

module tl_sram_adapter (
  input  wire logic                   clk_i,
  input  wire logic                   rst_ni,
  // TL A channel
  input  wire logic                   tl_a_valid_i,
  input  wire tl_sram_pkg::tl_a_t     tl_a_i,
  output logic                        tl_a_ready_o,
  // TL D channel
  output logic                        tl_d_valid_o,
  output tl_sram_pkg::tl_d_t          tl_d_o,
  input  wire logic                   tl_d_ready_i,
  // sram port
  output logic                        sram_req_o,
  input  wire logic                   sram_gnt_i,
  output logic                        sram_we_o,
  output tl_sram_pkg::sram_addr_t     sram_addr_o,
  output tl_sram_pkg::tl_data_t       sram_wdata_o,
  output tl_sram_pkg::tl_data_t       sram_wmask_o,
  input  wire tl_sram_pkg::tl_data_t  sram_rdata_i,
  input  wire logic                   sram_rvalid_i
);

  import tl_sram_pkg::*;

  sram_req_t req;
  logic      req_start;
  logic      idle;
  logic      rsp_valid;
  tl_data_t  rsp_rdata;
  logic      rsp_done;

  tl_a_decode i_decode (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .tl_a_valid_i (tl_a_valid_i),
    .tl_a_i       (tl_a_i),
    .idle_i       (idle),
    .tl_a_ready_o (tl_a_ready_o),
    .req_start_o  (req_start),
    .req_o        (req)
  );

  sram_access_ctrl i_execute (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_start_i   (req_start),
    .req_i         (req),
    .sram_gnt_i    (sram_gnt_i),
    .sram_rdata_i  (sram_rdata_i),
    .sram_rvalid_i (sram_rvalid_i),
    .rsp_done_i    (rsp_done),
    .idle_o        (idle),
    .sram_req_o    (sram_req_o),
    .sram_we_o     (sram_we_o),
    .sram_addr_o   (sram_addr_o),
    .sram_wdata_o  (sram_wdata_o),
    .sram_wmask_o  (sram_wmask_o),
    .rsp_valid_o   (rsp_valid),
    .rsp_rdata_o   (rsp_rdata)
  );

  tl_d_response i_response (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_i        (req),
    .rsp_valid_i  (rsp_valid),
    .rsp_rdata_i  (rsp_rdata),
    .tl_d_ready_i (tl_d_ready_i),
    .tl_d_valid_o (tl_d_valid_o),
    .tl_d_o       (tl_d_o),
    .rsp_done_o   (rsp_done)
  );

endmodule

`default_nettype wire

// ==== source/tl_sram_pkg.sv ====
// shared widths, TileLink opcodes and channel structs; imported by every adapter file
`default_nettype none

package tl_sram_pkg;

  // TL-UL bus widths
  localparam int TL_DW   = 32;
  localparam int TL_DBW  = TL_DW / 8;
  localparam int TL_AW   = 32;
  localparam int TL_AIW  = 8;
  localparam int TL_SZW  = 2;
  // sram word address, taken from the TL address above the byte offset
  localparam int SRAM_AW = 10;

  typedef logic [TL_DW-1:0]   tl_data_t;
  typedef logic [TL_DBW-1:0]  tl_mask_t;
  typedef logic [TL_AW-1:0]   tl_addr_t;
  typedef logic [TL_AIW-1:0]  tl_source_t;
  typedef logic [TL_SZW-1:0]  tl_size_t;
  typedef logic [SRAM_AW-1:0] sram_addr_t;

  // A channel opcodes as defined by TileLink
  typedef enum logic [2:0] {
    PutFullData    = 3'h0,
    PutPartialData = 3'h1,
    ArithmeticData = 3'h2,
    LogicalData    = 3'h3,
    Get            = 3'h4,
    Intent         = 3'h5
  } tl_a_op_e;

  typedef enum logic [2:0] {
    AccessAck     = 3'h0,
    AccessAckData = 3'h1
  } tl_d_op_e;

  // internal request class after decode
  typedef enum logic [1:0] {
    OpWrite,
    OpRead,
    OpAtomic,
    OpError
  } req_op_e;

  // arithmetic params map to 0..4, logical params to 5..8
  typedef enum logic [3:0] {
    FnMin  = 4'd0,
    FnMax  = 4'd1,
    FnMinU = 4'd2,
    FnMaxU = 4'd3,
    FnAdd  = 4'd4,
    FnXor  = 4'd5,
    FnOr   = 4'd6,
    FnAnd  = 4'd7,
    FnSwap = 4'd8
  } atomic_fn_e;

  typedef struct packed {
    tl_a_op_e   opcode;
    logic [2:0] param;
    tl_size_t   size;
    tl_source_t source;
    tl_addr_t   address;
    tl_mask_t   mask;
    tl_data_t   data;
  } tl_a_t;

  typedef struct packed {
    tl_d_op_e   opcode;
    tl_size_t   size;
    tl_source_t source;
    tl_data_t   data;
    logic       error;
  } tl_d_t;

  // decoded request, held for the whole transaction
  typedef struct packed {
    req_op_e    op;
    atomic_fn_e fn;
    sram_addr_t addr;
    tl_mask_t   mask;
    tl_data_t   data;
    tl_size_t   size;
    tl_source_t source;
  } sram_req_t;

  // byte enables to a per-bit mask
  function automatic tl_data_t mask_to_bits(tl_mask_t mask);
    tl_data_t bits;
    for (int i = 0; i < TL_DBW; i++) begin
      bits[8*i +: 8] = {8{mask[i]}};
    end
    return bits;
  endfunction

endpackage

`default_nettype wire

// ==== tl_sram_adapter.f ====
source/tl_sram_pkg.sv
source/atomic_alu.sv
source/tl_a_decode.sv
source/sram_access_ctrl.sv
source/tl_d_response.sv
source/tl_sram_adapter.sv
verif/tl_sram_checker.sv
verif/tb_tl_sram_adapter.sv

// ==== verif/tb_tl_sram_adapter.sv ====
// testbench top for the TL-UL to SRAM adapter with clock, reset, random requests, SRAM model and report
`default_nettype none

module tb_tl_sram_adapter;

  import tl_sram_pkg::*;

  localparam int NUM_REQ   = 400;
  localparam int MEM_WORDS = 1 << SRAM_AW;

  logic       clk_i = 1'b0;
  logic       rst_ni;
  logic       tl_a_valid_i;
  tl_a_t      tl_a_i;
  logic       tl_a_ready_o;
  logic       tl_d_valid_o;
  tl_d_t      tl_d_o;
  logic       tl_d_ready_i;
  logic       sram_req_o;
  logic       sram_gnt_i;
  logic       sram_we_o;
  sram_addr_t sram_addr_o;
  tl_data_t   sram_wdata_o;
  tl_data_t   sram_wmask_o;
  tl_data_t   sram_rdata_i;
  logic       sram_rvalid_i;

  logic [31:0] rng;
  tl_data_t    mem [MEM_WORDS];
  // read in flight inside the sram model
  logic        rd_busy = 1'b0;
  int          rd_wait = 0;
  tl_data_t    rd_word = '0;
  int          mismatches;
  int          proto_errors;
  int          responses;

  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  // every address gets its own start value
  function automatic tl_data_t fill_word(sram_addr_t w);
    return {w, ~w, w ^ 10'h2a5, 2'b01};
  endfunction

  // drives one A beat with random fields after a random gap and holds it until accepted
  task automatic send_request();
    logic [31:0] r;
    tl_a_t       a;
    r = next_rand();
    repeat (r[1:0]) @(negedge clk_i);
    r = next_rand();
    a = '0;
    case (r[3:0])
      4'd0, 4'd1, 4'd2: a.opcode = PutFullData;
      4'd3, 4'd4:       a.opcode = PutPartialData;
      4'd5, 4'd6:       a.opcode = ArithmeticData;
      4'd7, 4'd8:       a.opcode = LogicalData;
      4'd14:            a.opcode = Intent;
      // opcodes 6 and 7 are undefined
      4'd15:            a.opcode = tl_a_op_e'({2'b11, r[4]});
      default:          a.opcode = Get;
    endcase
    // mostly legal params with some out of range
    a.param   = r[6] ? {1'b0, r[8:7]} : r[10:8];
    a.size    = r[12:11];
    a.source  = r[20:13];
    a.mask    = (a.opcode == PutFullData) ? 4'hf : r[24:21];
    // 16 word window
    a.address = {20'h0, 6'h01, r[28:25], 2'b00};
    a.data    = next_rand();
    tl_a_i       = a;
    tl_a_valid_i = 1'b1;
    // ready only moves on the rising edge, so it is settled at the falling edge
    while (!tl_a_ready_o) @(negedge clk_i);
    @(negedge clk_i);
    tl_a_valid_i = 1'b0;
  endtask

  task automatic finish_run(input logic timed_out);
    $display("errors: %0d mismatches, %0d protocol, %0d of %0d responses",
             mismatches, proto_errors, responses, NUM_REQ);
    if (!timed_out && mismatches == 0 && proto_errors == 0 && responses == NUM_REQ) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  endtask

  // clock starts low from its declaration, first rising edge at 2
  initial begin
    forever #2 clk_i = ~clk_i;
  end

  initial begin
    rng           = 32'h3647;
    rst_ni        = 1'b0;
    tl_a_valid_i  = 1'b0;
    tl_a_i        = '0;
    tl_d_ready_i  = 1'b0;
    sram_gnt_i    = 1'b0;
    sram_rdata_i  = '0;
    sram_rvalid_i = 1'b0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = fill_word(sram_addr_t'(i));
    end
    repeat (10) @(negedge clk_i);
    rst_ni = 1'b1;
    for (int n = 0; n < NUM_REQ; n++) begin
      send_request();
    end
    wait (responses == NUM_REQ);
    // a few idle cycles to catch a stray D beat
    repeat (5) @(posedge clk_i);
    finish_run(1'b0);
  end

  // sram model and D ready change on the falling edge
  // req and its fields only move on the rising edge, so a grant given here is known to land
  always @(negedge clk_i) begin : drive_sram
    logic [31:0] r;
    r             = next_rand();
    tl_d_ready_i  = rst_ni & (r[1:0] != 2'b00);
    sram_gnt_i    = rst_ni & (r[3:2] != 2'b00);
    sram_rvalid_i = 1'b0;
    sram_rdata_i  = next_rand();
    if (rd_busy) begin
      if (rd_wait <= 1) begin
        sram_rvalid_i = 1'b1;
        sram_rdata_i  = rd_word;
        rd_busy       = 1'b0;
      end else begin
        rd_wait = rd_wait - 1;
      end
    end
    if (sram_req_o && sram_gnt_i) begin
      if (sram_we_o) begin
        mem[sram_addr_o] = (mem[sram_addr_o] & ~sram_wmask_o) | (sram_wdata_o & sram_wmask_o);
      end else begin
        // data returns 1 to 3 cycles after the grant
        rd_busy = 1'b1;
        rd_wait = int'(r % 32'd3) + 1;
        rd_word = mem[sram_addr_o];
      end
    end
  end

  initial begin
    repeat (NUM_REQ * 40) @(posedge clk_i);
    $display("timeout: %0d requests not completed within %0d cycles", NUM_REQ, NUM_REQ * 40);
    finish_run(1'b1);
  end

  tl_sram_adapter i_tl_sram_adapter (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .tl_a_valid_i  (tl_a_valid_i),
    .tl_a_i        (tl_a_i),
    .tl_a_ready_o  (tl_a_ready_o),
    .tl_d_valid_o  (tl_d_valid_o),
    .tl_d_o        (tl_d_o),
    .tl_d_ready_i  (tl_d_ready_i),
    .sram_req_o    (sram_req_o),
    .sram_gnt_i    (sram_gnt_i),
    .sram_we_o     (sram_we_o),
    .sram_addr_o   (sram_addr_o),
    .sram_wdata_o  (sram_wdata_o),
    .sram_wmask_o  (sram_wmask_o),
    .sram_rdata_i  (sram_rdata_i),
    .sram_rvalid_i (sram_rvalid_i)
  );

  tl_sram_checker i_checker (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .tl_a_valid_i      (tl_a_valid_i),
    .tl_a_i            (tl_a_i),
    .tl_a_ready_i      (tl_a_ready_o),
    .tl_d_valid_i      (tl_d_valid_o),
    .tl_d_i            (tl_d_o),
    .tl_d_ready_i      (tl_d_ready_i),
    .sram_req_i        (sram_req_o),
    .mismatches_o      (mismatches),
    .protocol_errors_o (proto_errors),
    .responses_o       (responses)
  );

endmodule

`default_nettype wire

// ==== verif/tl_sram_checker.sv ====
// testbench checker: reference memory, predicted D beats and handshake rules for the adapter
`default_nettype none

module tl_sram_checker (
  input  wire logic               clk_i,
  input  wire logic               rst_ni,
  input  wire logic               tl_a_valid_i,
  input  wire tl_sram_pkg::tl_a_t tl_a_i,
  input  wire logic               tl_a_ready_i,
  input  wire logic               tl_d_valid_i,
  input  wire tl_sram_pkg::tl_d_t tl_d_i,
  input  wire logic               tl_d_ready_i,
  input  wire logic               sram_req_i,
  output int                      mismatches_o,
  output int                      protocol_errors_o,
  output int                      responses_o
);

  import tl_sram_pkg::*;

  tl_data_t ref_mem [1 << SRAM_AW];
  tl_d_t    exp_q [$];
  int       outstanding;
  logic     stalled;
  tl_d_t    held;
  logic     reset_seen;

  // same start values as the sram model
  function automatic tl_data_t fill_word(sram_addr_t w);
    return {w, ~w, w ^ 10'h2a5, 2'b01};
  endfunction

  function automatic tl_data_t byte_bits(tl_mask_t m);
    tl_data_t b;
    for (int i = 0; i < 4; i++) begin
      b[8*i +: 8] = m[i] ? 8'hff : 8'h00;
    end
    return b;
  endfunction

  // new memory word for a legal atomic
  function automatic tl_data_t atomic_model(logic logical, logic [2:0] param,
                                            tl_data_t old, tl_data_t opnd);
    if (logical) begin
      case (param)
        3'd0: return old ^ opnd;
        3'd1: return old | opnd;
        3'd2: return old & opnd;
        default: return opnd;
      endcase
    end
    case (param)
      3'd0: return ($signed(old) < $signed(opnd)) ? old : opnd;
      3'd1: return ($signed(old) > $signed(opnd)) ? old : opnd;
      3'd2: return (old < opnd) ? old : opnd;
      3'd3: return (old > opnd) ? old : opnd;
      default: return old + opnd;
    endcase
  endfunction

  // applies one accepted A beat to the reference and queues its D beat
  task automatic predict(tl_a_t a);
    tl_d_t      d;
    tl_data_t   bits;
    tl_data_t   old;
    sram_addr_t idx;
    logic       legal_atomic;
    idx  = a.address[11:2];
    bits = byte_bits(a.mask);
    old  = ref_mem[idx];
    d    = '{opcode: AccessAck, size: a.size, source: a.source, data: '0, error: 1'b0};
    legal_atomic = (a.opcode == ArithmeticData && a.param <= 3'd4) ||
                   (a.opcode == LogicalData && a.param <= 3'd3);
    if (a.opcode == PutFullData || a.opcode == PutPartialData) begin
      ref_mem[idx] = (old & ~bits) | (a.data & bits);
    end else if (a.opcode == Get) begin
      d.opcode = AccessAckData;
      d.data   = old & bits;
    end else if (legal_atomic) begin
      d.opcode = AccessAckData;
      d.data   = old & bits;
      ref_mem[idx] = (old & ~bits) |
                     (atomic_model(a.opcode == LogicalData, a.param, old, a.data) & bits);
    end else begin
      // memory untouched
      d.error = 1'b1;
    end
    exp_q.push_back(d);
  endtask

  task automatic check_response(tl_d_t got);
    tl_d_t exp;
    if (exp_q.size() == 0) begin
      $display("ERROR @%0t: D beat with no request pending", $time);
      protocol_errors_o++;
    end else begin
      exp = exp_q.pop_front();
      responses_o++;
      if (got.opcode !== exp.opcode || got.size !== exp.size ||
          got.source !== exp.source || got.error !== exp.error) begin
        $display("MISMATCH @%0t: op %0d size %0d src %0h err %0b, expected %0d %0d %0h %0b",
                 $time, got.opcode, got.size, got.source, got.error,
                 exp.opcode, exp.size, exp.source, exp.error);
        mismatches_o++;
      end
      // data only counts with AccessAckData
      if (exp.opcode == AccessAckData && got.data !== exp.data) begin
        $display("MISMATCH @%0t: src %0h data %08h, expected %08h",
                 $time, exp.source, got.data, exp.data);
        mismatches_o++;
      end
    end
  endtask

  initial begin
    mismatches_o      = 0;
    protocol_errors_o = 0;
    responses_o       = 0;
    outstanding       = 0;
    stalled           = 1'b0;
    held              = '0;
    reset_seen        = 1'b0;
    for (int i = 0; i < (1 << SRAM_AW); i++) begin
      ref_mem[i] = fill_word(sram_addr_t'(i));
    end
  end

  // values read here are the ones from before the edge
  always @(posedge clk_i) begin
    if (rst_ni) begin
      if (!reset_seen) begin
        reset_seen = 1'b1;
        if (!tl_a_ready_i || tl_d_valid_i || sram_req_i) begin
          $display("ERROR @%0t: wrong state after reset, a_ready %0b d_valid %0b sram_req %0b",
                   $time, tl_a_ready_i, tl_d_valid_i, sram_req_i);
          protocol_errors_o++;
        end
      end
      if (stalled && (!tl_d_valid_i || tl_d_i !== held)) begin
        $display("ERROR @%0t: D beat dropped or changed while the host stalled", $time);
        protocol_errors_o++;
      end
      // an accept on the D transfer edge is already too early
      if (tl_a_valid_i && tl_a_ready_i) begin
        if (outstanding != 0) begin
          $display("ERROR @%0t: A beat accepted before the previous response was taken", $time);
          protocol_errors_o++;
        end
        outstanding++;
        predict(tl_a_i);
      end
      if (tl_d_valid_i && tl_d_ready_i) begin
        if (outstanding > 0) begin
          outstanding--;
        end
        check_response(tl_d_i);
      end
      stalled = tl_d_valid_i && !tl_d_ready_i;
      held    = tl_d_i;
    end
  end

endmodule

`default_nettype wire
